// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // datapath sizes
    localparam int WORD_W     = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);
    localparam int COUNT_W    = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W-1:0]     addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [COUNT_W-1:0]    count_t;
    typedef logic [2:0]            alu_op_t;
    typedef logic [1:0]            br_kind_t;

    // sequential fetch step
    localparam addr_t INST_BYTES = 32'd4;

    //////////////////////////////////////////////////////////////////////
    // RV32I encodings of the supported subset
    //////////////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // alu selector
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // control transfer kind
    localparam br_kind_t BR_NONE = 2'd0;
    localparam br_kind_t BR_EQ   = 2'd1;
    localparam br_kind_t BR_NE   = 2'd2;
    localparam br_kind_t BR_JAL  = 2'd3;

    typedef enum logic [1:0] {
        RUN,
        REDIRECT,
        SEEK
    } redirect_state_e;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+verification
common/core_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/redirect_fsm.sv
rtl/branch_counters.sv
rtl/pipe_core.sv
verification/tb_core.sv

// ==== rtl/branch_counters.sv ====
`default_nettype none
`timescale 1ns/1ps

module branch_counters (
    input  wire              clk,
    input  wire              arst_n_i,
    input  logic             retire_i,
    input  logic             branch_i,
    input  logic             redirect_i,
    output core_pkg::count_t retired_count_o,
    output core_pkg::count_t branch_count_o,
    output core_pkg::count_t redirect_count_o
);

    logic [2:0]       strobe;
    core_pkg::count_t count_q [3];

    assign strobe = {redirect_i, branch_i, retire_i};

    // free running, wraps at full scale
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 3; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (strobe[i]) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    assign retired_count_o  = count_q[0];
    assign branch_count_o   = count_q[1];
    assign redirect_count_o = count_q[2];

    // a control transfer is always a retiring instruction too
    a_branch_retires: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        branch_i |-> retire_i
    );

endmodule

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module exec_unit (
    input  core_pkg::addr_t    pc_i,
    input  core_pkg::word_t    op_a_i,
    input  core_pkg::word_t    op_b_i,
    input  core_pkg::word_t    imm_i,
    input  logic               use_imm_i,
    input  core_pkg::alu_op_t  alu_op_i,
    input  core_pkg::br_kind_t br_kind_i,
    output core_pkg::word_t    result_o,
    output logic               taken_o,
    output core_pkg::addr_t    target_o
);

    core_pkg::word_t operand_b;
    core_pkg::word_t alu_out;

    assign operand_b = use_imm_i ? imm_i : op_b_i;

    //////////////////////////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (alu_op_i)
            core_pkg::ALU_ADD:    alu_out = op_a_i + operand_b;
            core_pkg::ALU_SUB:    alu_out = op_a_i - operand_b;
            core_pkg::ALU_AND:    alu_out = op_a_i & operand_b;
            core_pkg::ALU_OR:     alu_out = op_a_i | operand_b;
            core_pkg::ALU_XOR:    alu_out = op_a_i ^ operand_b;
            core_pkg::ALU_PASS_B: alu_out = operand_b;
            default:              alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // branch resolution
    //////////////////////////////////////////////////////////////////////
    // branches always compare the two registers
    always_comb begin
        case (br_kind_i)
            core_pkg::BR_EQ:  taken_o = (op_a_i == op_b_i);
            core_pkg::BR_NE:  taken_o = (op_a_i != op_b_i);
            core_pkg::BR_JAL: taken_o = 1'b1;
            default:          taken_o = 1'b0;
        endcase
    end

    // jal links the return address
    assign result_o = (br_kind_i == core_pkg::BR_JAL) ? pc_i + core_pkg::INST_BYTES : alu_out;

    assign target_o = pc_i + imm_i;

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::word_t     inst_i,
    output core_pkg::reg_addr_t rs1_o,
    output core_pkg::reg_addr_t rs2_o,
    output core_pkg::reg_addr_t rd_o,
    output logic                rf_wen_o,
    output core_pkg::alu_op_t   alu_op_o,
    output logic                use_imm_o,
    output core_pkg::br_kind_t  br_kind_o,
    output core_pkg::word_t     imm_o
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            writes_rd;
    core_pkg::word_t imm_i_type;
    core_pkg::word_t imm_b_type;
    core_pkg::word_t imm_j_type;
    core_pkg::word_t imm_u_type;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    // immediate formats
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
    assign imm_u_type = {inst_i[31:12], 12'b0};

    always_comb begin
        writes_rd = 1'b0;
        alu_op_o  = core_pkg::ALU_ADD;
        use_imm_o = 1'b0;
        br_kind_o = core_pkg::BR_NONE;
        imm_o     = imm_i_type;
        case (opcode)
            core_pkg::OPC_LUI: begin
                writes_rd = 1'b1;
                alu_op_o  = core_pkg::ALU_PASS_B;
                use_imm_o = 1'b1;
                imm_o     = imm_u_type;
            end
            core_pkg::OPC_JAL: begin
                writes_rd = 1'b1;
                br_kind_o = core_pkg::BR_JAL;
                imm_o     = imm_j_type;
            end
            core_pkg::OPC_BRANCH: begin
                imm_o = imm_b_type;
                if (funct3 == core_pkg::F3_BEQ) begin
                    br_kind_o = core_pkg::BR_EQ;
                end else if (funct3 == core_pkg::F3_BNE) begin
                    br_kind_o = core_pkg::BR_NE;
                end
            end
            core_pkg::OPC_OP_IMM: begin
                // only addi
                writes_rd = (funct3 == core_pkg::F3_ADD_SUB);
                use_imm_o = 1'b1;
            end
            core_pkg::OPC_OP: begin
                if (funct7 == core_pkg::F7_BASE) begin
                    writes_rd = 1'b1;
                    case (funct3)
                        core_pkg::F3_ADD_SUB: alu_op_o = core_pkg::ALU_ADD;
                        core_pkg::F3_XOR:     alu_op_o = core_pkg::ALU_XOR;
                        core_pkg::F3_OR:      alu_op_o = core_pkg::ALU_OR;
                        core_pkg::F3_AND:     alu_op_o = core_pkg::ALU_AND;
                        default:              writes_rd = 1'b0;
                    endcase
                end else if (funct7 == core_pkg::F7_SUB && funct3 == core_pkg::F3_ADD_SUB) begin
                    writes_rd = 1'b1;
                    alu_op_o  = core_pkg::ALU_SUB;
                end
            end
            default: begin
            end
        endcase
    end

    // x0 is never written
    assign rf_wen_o = writes_rd && (rd_o != '0);

endmodule

`default_nettype wire

// ==== rtl/pipe_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module pipe_core (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  logic                inst_valid_i,
    input  core_pkg::addr_t     inst_pc_i,
    input  core_pkg::word_t     inst_i,
    output logic                inst_ready_o,
    output logic                redirect_valid_o,
    output core_pkg::addr_t     redirect_pc_o,
    output logic                wb_valid_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o,
    output core_pkg::count_t    retired_count_o,
    output core_pkg::count_t    branch_count_o,
    output core_pkg::count_t    redirect_count_o
);

    logic                inst_fire;
    logic                squash;
    logic                accept_ok;
    logic                resolve_taken;

    // decode stage
    logic                d_valid;
    core_pkg::addr_t     d_pc;
    core_pkg::word_t     d_inst;
    core_pkg::reg_addr_t d_rs1;
    core_pkg::reg_addr_t d_rs2;
    core_pkg::reg_addr_t d_rd;
    logic                d_wen;
    core_pkg::alu_op_t   d_alu_op;
    logic                d_use_imm;
    core_pkg::br_kind_t  d_br_kind;
    core_pkg::word_t     d_imm;
    core_pkg::word_t     rf_rdata1;
    core_pkg::word_t     rf_rdata2;
    core_pkg::word_t     fwd_a;
    core_pkg::word_t     fwd_b;

    // execute stage
    logic                e_valid;
    core_pkg::addr_t     e_pc;
    core_pkg::reg_addr_t e_rd;
    logic                e_wen;
    core_pkg::alu_op_t   e_alu_op;
    logic                e_use_imm;
    core_pkg::br_kind_t  e_br_kind;
    core_pkg::word_t     e_imm;
    core_pkg::word_t     e_op_a;
    core_pkg::word_t     e_op_b;
    core_pkg::word_t     ex_result;
    logic                ex_taken;
    core_pkg::addr_t     ex_target;

    // writeback stage
    logic                w_valid;
    core_pkg::reg_addr_t w_addr;
    core_pkg::word_t     w_data;

    assign inst_fire     = inst_valid_i && inst_ready_o;
    assign resolve_taken = e_valid && ex_taken;

    //////////////////////////////////////////////////////////////////////
    // pipeline registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            // wrong path behind a taken transfer is dropped
            d_valid <= !squash && inst_fire && accept_ok;
            e_valid <= !squash && d_valid;
            w_valid <= e_valid && e_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_fire) begin
            d_pc   <= inst_pc_i;
            d_inst <= inst_i;
        end
        e_pc      <= d_pc;
        e_rd      <= d_rd;
        e_wen     <= d_wen;
        e_alu_op  <= d_alu_op;
        e_use_imm <= d_use_imm;
        e_br_kind <= d_br_kind;
        e_imm     <= d_imm;
        e_op_a    <= fwd_a;
        e_op_b    <= fwd_b;
        w_addr    <= e_rd;
        w_data    <= ex_result;
    end

    // forwarding, youngest producer wins
    assign fwd_a = (e_valid && e_wen && e_rd == d_rs1) ? ex_result :
                   (w_valid && w_addr == d_rs1)        ? w_data    : rf_rdata1;
    assign fwd_b = (e_valid && e_wen && e_rd == d_rs2) ? ex_result :
                   (w_valid && w_addr == d_rs2)        ? w_data    : rf_rdata2;

    assign wb_valid_o = w_valid;
    assign wb_addr_o  = w_addr;
    assign wb_data_o  = w_data;

    //////////////////////////////////////////////////////////////////////
    // submodules
    //////////////////////////////////////////////////////////////////////
    inst_decoder i_decoder (
        .inst_i    (d_inst),
        .rs1_o     (d_rs1),
        .rs2_o     (d_rs2),
        .rd_o      (d_rd),
        .rf_wen_o  (d_wen),
        .alu_op_o  (d_alu_op),
        .use_imm_o (d_use_imm),
        .br_kind_o (d_br_kind),
        .imm_o     (d_imm)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .rs1_i    (d_rs1),
        .rs2_i    (d_rs2),
        .wen_i    (w_valid),
        .waddr_i  (w_addr),
        .wdata_i  (w_data),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    exec_unit i_exec (
        .pc_i      (e_pc),
        .op_a_i    (e_op_a),
        .op_b_i    (e_op_b),
        .imm_i     (e_imm),
        .use_imm_i (e_use_imm),
        .alu_op_i  (e_alu_op),
        .br_kind_i (e_br_kind),
        .result_o  (ex_result),
        .taken_o   (ex_taken),
        .target_o  (ex_target)
    );

    redirect_fsm i_redirect (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .resolve_taken_i  (resolve_taken),
        .target_i         (ex_target),
        .accept_i         (inst_fire),
        .accept_pc_i      (inst_pc_i),
        .squash_o         (squash),
        .accept_ok_o      (accept_ok),
        .inst_ready_o     (inst_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    branch_counters i_counters (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .retire_i         (e_valid),
        .branch_i         (e_valid && e_br_kind != core_pkg::BR_NONE),
        .redirect_i       (resolve_taken),
        .retired_count_o  (retired_count_o),
        .branch_count_o   (branch_count_o),
        .redirect_count_o (redirect_count_o)
    );

endmodule

`default_nettype wire

// ==== rtl/redirect_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module redirect_fsm (
    input  wire              clk,
    input  wire              arst_n_i,
    input  logic             resolve_taken_i,
    input  core_pkg::addr_t  target_i,
    input  logic             accept_i,
    input  core_pkg::addr_t  accept_pc_i,
    output logic             squash_o,
    output logic             accept_ok_o,
    output logic             inst_ready_o,
    output logic             redirect_valid_o,
    output core_pkg::addr_t  redirect_pc_o
);

    core_pkg::redirect_state_e state_q;
    core_pkg::redirect_state_e state_d;
    core_pkg::addr_t           target_q;
    logic                      seek_hit;

    // first accepted instruction on the new path
    assign seek_hit = accept_i && (accept_pc_i == target_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            core_pkg::RUN:      if (resolve_taken_i) state_d = core_pkg::REDIRECT;
            core_pkg::REDIRECT: state_d = core_pkg::SEEK;
            core_pkg::SEEK:     if (seek_hit) state_d = core_pkg::RUN;
            default:            state_d = core_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= core_pkg::RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (squash_o) begin
            target_q <= target_i;
        end
    end

    assign squash_o         = (state_q == core_pkg::RUN) && resolve_taken_i;
    assign accept_ok_o      = (state_q == core_pkg::RUN) ||
                              ((state_q == core_pkg::SEEK) && seek_hit);
    assign inst_ready_o     = (state_q != core_pkg::REDIRECT);
    assign redirect_valid_o = (state_q == core_pkg::REDIRECT);
    assign redirect_pc_o    = target_q;

    // pipeline is empty until the target arrives, so no second taken transfer
    a_taken_only_in_run: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        resolve_taken_i |-> (state_q == core_pkg::RUN)
    );

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  core_pkg::reg_addr_t rs1_i,
    input  core_pkg::reg_addr_t rs2_i,
    input  logic                wen_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::word_t     wdata_i,
    output core_pkg::word_t     rdata1_o,
    output core_pkg::word_t     rdata2_o
);

    // x0 has no storage
    core_pkg::word_t regs [1:core_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

    // decoder must have dropped any x0 destination long before writeback
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        wen_i |-> (waddr_i != '0)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f compile.f --Mdir obj_dir -o tb_core_sim > build.log 2>&1 \
    && ./obj_dir/tb_core_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
    && { echo "simulation reported failures, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== verification/tb_tests.svh ====
    // random operands through lui and addi, then every alu operation
    task automatic test_alu_ops();
        cur_test = "alu_ops";
        prog_len = 0;
        for (int r = 0; r < 3; r++) begin
            emit(K_LUI, 5'd1, 5'd0, 5'd0, rand_bits(20) << 12);
            emit(K_ADDI, 5'd1, 5'd1, 5'd0, rand_bits(12));
            emit(K_LUI, 5'd2, 5'd0, 5'd0, rand_bits(20) << 12);
            emit(K_ADDI, 5'd2, 5'd2, 5'd0, rand_bits(12));
            emit(K_ADD, 5'd3, 5'd1, 5'd2, 32'd0);
            emit(K_SUB, 5'd4, 5'd1, 5'd2, 32'd0);
            emit(K_AND, 5'd5, 5'd1, 5'd2, 32'd0);
            emit(K_OR, 5'd6, 5'd1, 5'd2, 32'd0);
            emit(K_XOR, 5'd7, 5'd1, 5'd2, 32'd0);
            emit(K_ADDI, 5'd8, 5'd3, 5'd0, rand_bits(12));
            emit(K_SUB, 5'd9, 5'd7, 5'd1, 32'd0);
        end
        run_program();
    endtask

    // chains that need execute and writeback forwarding
    task automatic test_forwarding();
        cur_test = "forwarding";
        prog_len = 0;
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
        emit(K_ADDI, 5'd2, 5'd1, 5'd0, 32'd3);
        emit(K_ADD, 5'd3, 5'd2, 5'd1, 32'd0);
        emit(K_SUB, 5'd4, 5'd3, 5'd2, 32'd0);
        emit(K_XOR, 5'd5, 5'd1, 5'd4, 32'd0);
        emit(K_ADDI, 5'd6, 5'd4, 5'd0, -32'sd9);
        emit(K_ADD, 5'd6, 5'd6, 5'd6, 32'd0);
        emit(K_OR, 5'd7, 5'd6, 5'd5, 32'd0);
        emit(K_AND, 5'd8, 5'd7, 5'd6, 32'd0);
        emit(K_ADD, 5'd1, 5'd8, 5'd7, 32'd0);
        emit(K_SUB, 5'd9, 5'd1, 5'd1, 32'd0);
        run_program();
    endtask

    // taken and not taken branches, jal links, a small backward loop
    task automatic test_branches();
        cur_test = "branches";
        prog_len = 0;
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 32'd1);
        emit(K_ADDI, 5'd2, 5'd0, 5'd0, 32'd1);
        emit(K_BEQ, 5'd0, 5'd1, 5'd2, 32'd12);
        emit(K_ADDI, 5'd3, 5'd0, 5'd0, 32'd99);
        emit(K_ADDI, 5'd3, 5'd0, 5'd0, 32'd98);
        emit(K_BNE, 5'd0, 5'd1, 5'd2, 32'd8);
        emit(K_ADDI, 5'd4, 5'd0, 5'd0, 32'd4);
        emit(K_BEQ, 5'd0, 5'd1, 5'd0, 32'd8);
        emit(K_BNE, 5'd0, 5'd1, 5'd0, 32'd12);
        emit(K_ADDI, 5'd5, 5'd0, 5'd0, 32'd55);
        emit(K_ADDI, 5'd5, 5'd0, 5'd0, 32'd56);
        emit(K_JAL, 5'd6, 5'd0, 5'd0, 32'd12);
        emit(K_ADDI, 5'd7, 5'd0, 5'd0, 32'd77);
        emit(K_ADDI, 5'd7, 5'd0, 5'd0, 32'd78);
        emit(K_ADD, 5'd8, 5'd6, 5'd4, 32'd0);
        emit(K_JAL, 5'd0, 5'd0, 5'd0, 32'd8);
        emit(K_ADDI, 5'd9, 5'd0, 5'd0, 32'd1);
        emit(K_ADDI, 5'd11, 5'd0, 5'd0, 32'd3);
        emit(K_ADDI, 5'd11, 5'd11, 5'd0, -32'sd1);
        emit(K_BNE, 5'd0, 5'd11, 5'd0, -32'sd4);
        emit(K_ADDI, 5'd12, 5'd6, 5'd0, 32'd5);
        run_program();
    endtask

    // x0 destinations and encodings outside the subset
    task automatic test_nops();
        cur_test = "nops";
        prog_len = 0;
        emit(K_ADDI, 5'd0, 5'd0, 5'd0, 32'd5);
        emit(K_ADDI, 5'd1, 5'd0, 5'd0, 32'd7);
        // custom-0 opcode
        emit(K_RAW, 5'd0, 5'd0, 5'd0, {12'h123, 5'd1, 3'b000, 5'd9, 7'b0001011});
        // sll
        emit(K_RAW, 5'd0, 5'd0, 5'd0, {7'b0000000, 5'd1, 5'd1, 3'b001, 5'd10, 7'b0110011});
        emit(K_ADD, 5'd0, 5'd1, 5'd1, 32'd0);
        // branch with a reserved funct3
        emit(K_RAW, 5'd0, 5'd0, 5'd0, {7'b0000000, 5'd1, 5'd1, 3'b010, 5'd8, 7'b1100011});
        // slti
        emit(K_RAW, 5'd0, 5'd0, 5'd0, {12'd5, 5'd1, 3'b010, 5'd11, 7'b0010011});
        emit(K_RAW, 5'd0, 5'd0, 5'd0, {7'b0100000, 5'd1, 5'd1, 3'b100, 5'd12, 7'b0110011});
        emit(K_LUI, 5'd0, 5'd0, 5'd0, 32'hABCD_E000);
        emit(K_ADDI, 5'd2, 5'd1, 5'd0, 32'd1);
        emit(K_ADD, 5'd3, 5'd2, 5'd9, 32'd0);
        run_program();
    endtask

// ==== verification/tb_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_core;

    typedef enum {
        K_LUI, K_JAL, K_BEQ, K_BNE, K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_RAW
    } kind_e;

    logic        clk;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_pc_i;
    logic [31:0] inst_i;
    logic        inst_ready_o;
    logic        redirect_valid_o;
    logic [31:0] redirect_pc_o;
    logic        wb_valid_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;
    logic [15:0] retired_count_o;
    logic [15:0] branch_count_o;
    logic [15:0] redirect_count_o;

    // program image plus the fields the model executes
    logic [31:0] prog_word [64];
    kind_e       prog_kind [64];
    logic [4:0]  prog_rd [64];
    logic [4:0]  prog_rs1 [64];
    logic [4:0]  prog_rs2 [64];
    logic [31:0] prog_imm [64];
    int          prog_len;

    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_targets [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [31:0] got_targets [$];
    int          exp_retired;
    int          exp_branches;
    int          exp_redirects;

    logic        fetch_en;
    logic [31:0] fetch_pc;
    logic        fire_seen;
    logic        redir_seen;
    logic [31:0] redir_target;

    logic [31:0] lfsr_q = 32'h9e53;
    string       cur_test;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    pipe_core i_dut (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .inst_valid_i     (inst_valid_i),
        .inst_pc_i        (inst_pc_i),
        .inst_i           (inst_i),
        .inst_ready_o     (inst_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .wb_valid_o       (wb_valid_o),
        .wb_addr_o        (wb_addr_o),
        .wb_data_o        (wb_data_o),
        .retired_count_o  (retired_count_o),
        .branch_count_o   (branch_count_o),
        .redirect_count_o (redirect_count_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run timed out after %0d cycles while %s was still running",
                     cycle_count, cur_test);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fetch source and output monitors
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        fire_seen    = inst_valid_i && inst_ready_o;
        redir_seen   = redirect_valid_o;
        redir_target = redirect_pc_o;
    end

    always @(posedge clk) begin
        #1;
        if (!fetch_en) begin
            fetch_pc = '0;
        end else if (redir_seen) begin
            fetch_pc = redir_target;
        end else if (fire_seen) begin
            fetch_pc = fetch_pc + 32'd4;
        end
        // past the end of the program the source goes idle
        inst_valid_i = fetch_en && (fetch_pc[31:2] < prog_len);
        inst_pc_i    = fetch_pc;
        inst_i       = inst_valid_i ? prog_word[fetch_pc[7:2]] : '0;
    end

    always @(negedge clk) begin
        if (wb_valid_o) begin
            got_addr.push_back({27'd0, wb_addr_o});
            got_data.push_back(wb_data_o);
        end
        if (redirect_valid_o) begin
            got_targets.push_back(redirect_pc_o);
            check_value("ready during redirect", 32'd0, {31'd0, inst_ready_o});
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
        end
    endtask

    // galois form, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hA300_0000) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // assembler and reference model
    //////////////////////////////////////////////////////////////////////
    task automatic emit(input kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] word;
        logic [31:0] value;
        logic [2:0]  f3;
        value = imm;
        f3    = (kind == K_AND) ? 3'b111 : (kind == K_OR) ? 3'b110 :
                (kind == K_XOR) ? 3'b100 : (kind == K_BNE) ? 3'b001 : 3'b000;
        case (kind)
            K_LUI: begin
                value = {imm[31:12], 12'h000};
                word  = {imm[31:12], rd, 7'b0110111};
            end
            K_JAL: begin
                value = {{11{imm[20]}}, imm[20:1], 1'b0};
                word  = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            end
            K_BEQ, K_BNE: begin
                value = {{19{imm[12]}}, imm[12:1], 1'b0};
                word  = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            end
            K_ADDI: begin
                value = {{20{imm[11]}}, imm[11:0]};
                word  = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            end
            K_RAW: begin
                word = imm;
            end
            default: begin
                word = {(kind == K_SUB) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd,
                        7'b0110011};
            end
        endcase
        prog_word[prog_len] = word;
        prog_kind[prog_len] = kind;
        prog_rd[prog_len]   = rd;
        prog_rs1[prog_len]  = rs1;
        prog_rs2[prog_len]  = rs2;
        prog_imm[prog_len]  = value;
        prog_len++;
    endtask

    task automatic run_model();
        logic [31:0] rf [32];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        writes;
        logic        taken;
        int          idx;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        exp_targets.delete();
        exp_retired   = 0;
        exp_branches  = 0;
        exp_redirects = 0;
        pc    = '0;
        steps = 0;
        while (pc[31:2] < prog_len && steps < 256) begin
            idx    = pc[31:2];
            a      = rf[prog_rs1[idx]];
            b      = rf[prog_rs2[idx]];
            res    = '0;
            writes = 1'b1;
            taken  = 1'b0;
            case (prog_kind[idx])
                K_LUI:  res = prog_imm[idx];
                K_ADDI: res = a + prog_imm[idx];
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_JAL: begin
                    res   = pc + 32'd4;
                    taken = 1'b1;
                end
                K_BEQ: begin
                    writes = 1'b0;
                    taken  = (a == b);
                end
                K_BNE: begin
                    writes = 1'b0;
                    taken  = (a != b);
                end
                default: writes = 1'b0;
            endcase
            exp_retired++;
            if (prog_kind[idx] inside {K_JAL, K_BEQ, K_BNE}) begin
                exp_branches++;
            end
            // x0 stays zero and is never reported
            if (writes && prog_rd[idx] != 5'd0) begin
                rf[prog_rd[idx]] = res;
                exp_addr.push_back({27'd0, prog_rd[idx]});
                exp_data.push_back(res);
            end
            if (taken) begin
                exp_redirects++;
                pc = pc + prog_imm[idx];
                exp_targets.push_back(pc);
            end else begin
                pc = pc + 32'd4;
            end
            steps++;
        end
    endtask

    task automatic apply_reset();
        fetch_en = 1'b0;
        @(posedge clk);
        #1;
        arst_n_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk);
        fetch_en = 1'b1;
    endtask

    task automatic run_program();
        int start_errors;
        int n;
        start_errors = error_count;
        run_model();
        cycle_limit = cycle_limit + 40 * exp_retired + 20;
        got_addr.delete();
        got_data.delete();
        got_targets.delete();
        apply_reset();
        while (retired_count_o < exp_retired) begin
            @(negedge clk);
        end
        // let anything still in flight drain out
        repeat (4) @(negedge clk);
        #1;
        fetch_en = 1'b0;
        check_value("writeback count", exp_addr.size(), got_addr.size());
        n = (exp_addr.size() < got_addr.size()) ? exp_addr.size() : got_addr.size();
        for (int i = 0; i < n; i++) begin
            check_value("writeback register", exp_addr[i], got_addr[i]);
            check_value("writeback data", exp_data[i], got_data[i]);
        end
        check_value("redirect count", exp_targets.size(), got_targets.size());
        n = (exp_targets.size() < got_targets.size()) ? exp_targets.size() : got_targets.size();
        for (int i = 0; i < n; i++) begin
            check_value("redirect target", exp_targets[i], got_targets[i]);
        end
        check_value("retired counter", exp_retired, {16'd0, retired_count_o});
        check_value("branch counter", exp_branches, {16'd0, branch_count_o});
        check_value("redirect counter", exp_redirects, {16'd0, redirect_count_o});
        test_count++;
        $display("Test %s finished with %0d errors", cur_test, error_count - start_errors);
    endtask

`include "tb_tests.svh"

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        fetch_en     = 1'b0;
        fetch_pc     = '0;
        prog_len     = 0;
        test_alu_ops();
        test_forwarding();
        test_branches();
        test_nops();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
